/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench, exit status is the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 --top-module tbUsbEpBuffers \
        -f tb.f -o tbUsbEpBuffers &&
    ./obj_dir/tbUsbEpBuffers +verilator+error+limit+1000 ||
    { echo "Simulation failed"; exit 1; }

/* sim/tbUsbEpBuffers.sv */
module tbUsbEpBuffers;
    timeunit 1ns;
    timeprecision 100ps;
    import usbEpPkg::*;

    localparam int ENDPOINTS = 3;
    localparam int FIFO_DEPTH = 16;
    localparam int EP_W = $clog2(ENDPOINTS + 1);
    localparam int FIFOS = 2 * ENDPOINTS; // IN FIFOs first, then OUT FIFOs
    localparam int TIMEOUT = 5000;        // Cycles per wait loop
    localparam int TRANSACTIONS = 40;     // Per producer in the random phase

    logic clk12;
    logic rstN;
    logic [EP_W-1:0] rxEp;
    pushPortT rxPush;
    logic rxFull;
    logic [EP_W-1:0] txEp;
    popPortT txPop;
    logic txAvailable;
    logic [7:0] txData;
    pushPortT epOutFill [ENDPOINTS];
    logic [ENDPOINTS-1:0] epOutFull;
    popPortT epInPop [ENDPOINTS];
    logic [ENDPOINTS-1:0] epInAvailable;
    logic [7:0] epInData [ENDPOINTS];

    logic [7:0] refQ [FIFOS][$]; // Committed bytes in pop order
    logic trafficDone;

    usbEpBuffers #(
        .ENDPOINTS(ENDPOINTS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut0 (
        .clk12_i(clk12),
        .rstN_i(rstN),
        .rxEp_i(rxEp),
        .rxPush_i(rxPush),
        .rxFull_o(rxFull),
        .txEp_i(txEp),
        .txPop_i(txPop),
        .txAvailable_o(txAvailable),
        .txData_o(txData),
        .epOutFill_i(epOutFill),
        .epOutFull_o(epOutFull),
        .epInPop_i(epInPop),
        .epInAvailable_o(epInAvailable),
        .epInData_o(epInData)
    );

    initial clk12 = 1'b0;
    always #50 clk12 = ~clk12;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(negedge clk12) begin
        if (dut0.chk0.failCount != 0) stopOnError("A protocol assertion in the checker failed");
    end

    function automatic pushPortT makePush(input logic v, input logic [7:0] d,
                                          input logic done, input logic ok);
        pushPortT p;
        p.dataValid = v;
        p.data = d;
        p.transDone = done;
        p.transSuccess = ok;
        return p;
    endfunction

    function automatic popPortT makePop(input logic pop, input logic done, input logic ok);
        popPortT p;
        p.pop = pop;
        p.transDone = done;
        p.transSuccess = ok;
        return p;
    endfunction

    // FIFOs below ENDPOINTS are reached through the engine rx port
    function automatic logic fullOf(input int f);
        if (f < ENDPOINTS) return rxFull;
        return epOutFull[f - ENDPOINTS];
    endfunction

    function automatic logic availOf(input int f);
        if (f < ENDPOINTS) return epInAvailable[f];
        return txAvailable;
    endfunction

    function automatic logic [7:0] dataOf(input int f);
        if (f < ENDPOINTS) return epInData[f];
        return txData;
    endfunction

    function automatic int pendingBytes(input int first, input int count);
        int total;
        total = 0;
        for (int f = first; f < first + count; f++) begin
            total += refQ[f].size();
        end
        return total;
    endfunction

    task automatic setPush(input int f, input pushPortT p);
        if (f < ENDPOINTS) begin
            rxEp = EP_W'(f);
            rxPush = p;
        end else begin
            epOutFill[f - ENDPOINTS] = p;
        end
    endtask

    task automatic setPop(input int f, input popPortT p);
        if (f < ENDPOINTS) begin
            epInPop[f] = p;
        end else begin
            txEp = EP_W'(f - ENDPOINTS);
            txPop = p;
        end
    endtask

    task automatic pushTrans(input int f, input int n, input logic ok);
        logic [7:0] pending [$];
        logic [7:0] b;
        int guard;
        setPush(f, '0);
        @(negedge clk12); // Endpoint select settles
        for (int i = 0; i < n; i++) begin
            guard = 0;
            while (fullOf(f)) begin
                @(negedge clk12);
                guard++;
                if (guard > TIMEOUT) stopOnError($sformatf("Timeout, FIFO %0d stayed full", f));
            end
            b = 8'($urandom);
            setPush(f, makePush(1'b1, b, 1'b0, 1'b0));
            pending.push_back(b);
            @(negedge clk12);
            setPush(f, '0);
        end
        setPush(f, makePush(1'b0, 8'h00, 1'b1, ok));
        @(negedge clk12);
        setPush(f, '0);
        if (ok) begin
            foreach (pending[i]) begin
                refQ[f].push_back(pending[i]);
            end
        end
    endtask

    task automatic popTrans(input int f, input int n, input logic ok);
        logic [7:0] expected;
        int guard;
        setPop(f, '0);
        @(negedge clk12);
        for (int i = 0; i < n; i++) begin
            guard = 0;
            while (!availOf(f)) begin
                @(negedge clk12);
                guard++;
                if (guard > TIMEOUT) stopOnError($sformatf("Timeout, FIFO %0d had no byte", f));
            end
            expected = refQ[f][i];
            assert (dataOf(f) == expected) else stopOnError($sformatf(
                "MISMATCH at time %0t: FIFO %0d byte %0d is %h, expected %h",
                $time, f, i, dataOf(f), expected));
            setPop(f, makePop(1'b1, 1'b0, 1'b0));
            @(negedge clk12);
            setPop(f, '0);
        end
        setPop(f, makePop(1'b0, 1'b1, ok));
        @(negedge clk12);
        setPop(f, '0);
        if (ok) begin
            repeat (n) refQ[f].delete(0); // Bytes are gone for good
        end
    endtask

    task automatic pushTraffic(input int first, input int count);
        for (int t = 0; t < TRANSACTIONS; t++) begin
            pushTrans(first + int'($urandom_range(count - 1)), int'($urandom_range(6, 1)),
                      $urandom_range(3) != 0);
        end
    endtask

    // Drains until the producers are done and nothing is left
    task automatic popTraffic(input int first, input int count);
        int f;
        int n;
        int idle;
        idle = 0;
        while (!trafficDone || pendingBytes(first, count) > 0) begin
            f = first + int'($urandom_range(count - 1));
            n = refQ[f].size();
            if (n == 0) begin
                @(negedge clk12);
                idle++;
                if (idle > TIMEOUT) stopOnError("Timeout, a consumer saw no data for too long");
            end else begin
                idle = 0;
                if (n > 6) n = 6;
                popTrans(f, int'($urandom_range(n, 1)), $urandom_range(3) != 0);
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha5ef2f3a));
        rstN = 1'b0;
        rxEp = '0;
        rxPush = '0;
        txEp = '0;
        txPop = '0;
        for (int e = 0; e < ENDPOINTS; e++) begin
            epOutFill[e] = '0;
            epInPop[e] = '0;
        end
        trafficDone = 1'b0;
        repeat (10) @(posedge clk12);
        @(negedge clk12);
        rstN = 1'b1;
        @(negedge clk12);

        assert (!rxFull && !txAvailable && epOutFull == '0 && epInAvailable == '0)
            else stopOnError("Flags are not low after reset");

        // In-order transfer in both directions
        pushTrans(ENDPOINTS, 5, 1'b1);
        popTrans(ENDPOINTS, 5, 1'b1);
        pushTrans(0, 5, 1'b1);
        popTrans(0, 5, 1'b1);

        // Rolled back push stays invisible
        pushTrans(1, 3, 1'b1);
        pushTrans(1, 4, 1'b0);
        popTrans(1, 3, 1'b1);
        repeat (20) @(negedge clk12);
        assert (!epInAvailable[1]) else stopOnError("Rolled back bytes became visible");

        pushTrans(ENDPOINTS + 1, 6, 1'b1);
        popTrans(ENDPOINTS + 1, 4, 1'b0); // Replayed by the next pop
        popTrans(ENDPOINTS + 1, 6, 1'b1);

        pushTrans(2, FIFO_DEPTH, 1'b1);
        assert (fullOf(2)) else stopOnError("FIFO not full after FIFO_DEPTH committed bytes");
        popTrans(2, 4, 1'b1);
        assert (!fullOf(2)) else stopOnError("FIFO still full after a committed pop");

        fork
            begin
                fork
                    pushTraffic(0, ENDPOINTS);
                    pushTraffic(ENDPOINTS, 1);
                    pushTraffic(ENDPOINTS + 1, 1);
                    pushTraffic(ENDPOINTS + 2, 1);
                join
                trafficDone = 1'b1;
            end
            popTraffic(ENDPOINTS, ENDPOINTS);
            popTraffic(0, 1);
            popTraffic(1, 1);
            popTraffic(2, 1);
        join

        @(negedge clk12);
        if (dut0.chk0.failCount != 0) begin
            stopOnError("A protocol assertion failed during the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* sim/usbEpBuffers_chk.sv */
module usbEpBuffersChk #(
    parameter int ENDPOINTS = 3,
    localparam int REQUESTERS = 2 * ENDPOINTS
)(
    input logic clk12_i,
    input logic rstN_i,
    input usbEpPkg::bufReqT bufReq_i [REQUESTERS],
    input logic [REQUESTERS-1:0] bufGrant_i,
    input usbEpPkg::pushPortT rxPush_i,
    input logic rxFull_i,
    input usbEpPkg::popPortT txPop_i,
    input logic txAvailable_i,
    input usbEpPkg::pushPortT epOutFill_i [ENDPOINTS],
    input logic [ENDPOINTS-1:0] epOutFull_i,
    input usbEpPkg::popPortT epInPop_i [ENDPOINTS],
    input logic [ENDPOINTS-1:0] epInAvailable_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import usbEpPkg::*;

    int unsigned failCount = 0; // Read by the testbench top
    logic [REQUESTERS-1:0] reqValid;

    always_comb begin
        for (int i = 0; i < REQUESTERS; i++) begin
            reqValid[i] = bufReq_i[i].valid;
        end
    end

    grantOneHot: assert property (@(posedge clk12_i) $onehot0(bufGrant_i))
        else begin
            failCount = failCount + 1;
            $error("More than one buffer grant in one cycle");
        end

    // Arbiter may only pick a FIFO that asks
    grantRequested: assert property (@(posedge clk12_i) (bufGrant_i & ~reqValid) == '0)
        else begin
            failCount = failCount + 1;
            $error("Buffer grant without a request");
        end

    resetFlags: assert property (@(posedge clk12_i) !rstN_i |->
        !rxFull_i && !txAvailable_i && (epOutFull_i == '0) && (epInAvailable_i == '0)
        && (reqValid == '0))
        else begin
            failCount = failCount + 1;
            $error("Flag or RAM request high during reset");
        end

    rxPushNotFull: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        rxPush_i.dataValid |-> !rxFull_i)
        else begin
            failCount = failCount + 1;
            $error("Engine pushed while the IN FIFO was full");
        end

    txPopAvailable: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        txPop_i.pop |-> txAvailable_i)
        else begin
            failCount = failCount + 1;
            $error("Engine popped while no OUT byte was available");
        end

    for (genvar e = 0; e < ENDPOINTS; e++) begin : gEpChk
        fillNotFull: assert property (@(posedge clk12_i) disable iff (!rstN_i)
            epOutFill_i[e].dataValid |-> !epOutFull_i[e])
            else begin
                failCount = failCount + 1;
                $error("Backend filled OUT endpoint %0d while full", e);
            end

        popAvailable: assert property (@(posedge clk12_i) disable iff (!rstN_i)
            epInPop_i[e].pop |-> epInAvailable_i[e])
            else begin
                failCount = failCount + 1;
                $error("Backend popped IN endpoint %0d with no byte", e);
            end
    end

endmodule

bind usbEpBuffers usbEpBuffersChk #(
    .ENDPOINTS(ENDPOINTS)
) chk0 (
    .clk12_i(clk12_i),
    .rstN_i(rstN_i),
    .bufReq_i(bufReq),
    .bufGrant_i(bufGrant),
    .rxPush_i(rxPush_i),
    .rxFull_i(rxFull_o),
    .txPop_i(txPop_i),
    .txAvailable_i(txAvailable_o),
    .epOutFill_i(epOutFill_i),
    .epOutFull_i(epOutFull_o),
    .epInPop_i(epInPop_i),
    .epInAvailable_i(epInAvailable_o)
);

/* source/bufferArbiter.sv */
module bufferArbiter #(
    parameter int REQUESTERS = 6
)(
    input logic clk12_i,
    input logic rstN_i,
    input usbEpPkg::bufReqT req_i [REQUESTERS],
    output logic [REQUESTERS-1:0] grant_o,
    output usbEpPkg::bufRspT rsp_o [REQUESTERS],
    output logic ramEn_o,
    output logic ramWe_o,
    output logic [usbEpPkg::BUF_ADDR_W-1:0] ramAddr_o,
    output logic [7:0] ramWdata_o,
    input logic [7:0] ramRdata_i
);
    import usbEpPkg::*;

    localparam int IDX_W = $clog2(REQUESTERS);

    logic [IDX_W-1:0] lastIdx;  // Round-robin start point
    logic [IDX_W-1:0] grantIdx;
    logic anyGrant;
    logic [IDX_W-1:0] rdIdx;    // Owner of the read in flight
    logic rdPending;
    bufReqT selReq;

    // Search starts just after the last grant
    always_comb begin
        int cand;
        grantIdx = '0;
        anyGrant = 1'b0;
        for (int k = 1; k <= REQUESTERS; k++) begin
            cand = (int'(lastIdx) + k) % REQUESTERS;
            if (!anyGrant && req_i[cand].valid) begin
                anyGrant = 1'b1;
                grantIdx = IDX_W'(cand);
            end
        end
    end

    assign selReq = req_i[grantIdx];

    always_comb begin
        grant_o = '0;
        if (anyGrant) grant_o[grantIdx] = 1'b1;
    end

    assign ramEn_o = anyGrant;
    assign ramWe_o = anyGrant && selReq.write;
    assign ramAddr_o = selReq.addr;
    assign ramWdata_o = selReq.data;

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            lastIdx <= IDX_W'(REQUESTERS - 1); // Requester 0 goes first
            rdIdx <= '0;
            rdPending <= 1'b0;
        end else begin
            if (anyGrant) lastIdx <= grantIdx;
            rdPending <= anyGrant && !selReq.write;
            rdIdx <= grantIdx;
        end
    end

    // Read data only reaches the requester that was granted
    always_comb begin
        for (int i = 0; i < REQUESTERS; i++) begin
            rsp_o[i].valid = rdPending && (rdIdx == IDX_W'(i));
            rsp_o[i].data = ramRdata_i;
        end
    end

endmodule

/* source/bufferRam.sv */
module bufferRam (
    input logic clk12_i,
    input logic en_i,
    input logic we_i,
    input logic [usbEpPkg::BUF_ADDR_W-1:0] addr_i,
    input logic [7:0] wdata_i,
    output logic [7:0] rdata_o
);
    import usbEpPkg::*;

    logic [7:0] mem [2**BUF_ADDR_W];

    // Single port, one access per cycle
    always_ff @(posedge clk12_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i]; // Valid in the next cycle
            end
        end
    end

endmodule

/* source/epPortMux.sv */
module epPortMux #(
    parameter int ENDPOINTS = 3,
    localparam int EP_W = $clog2(ENDPOINTS + 1)
)(
    input logic [EP_W-1:0] rxEp_i,
    input usbEpPkg::pushPortT rxPush_i,
    output logic rxFull_o,
    input logic [EP_W-1:0] txEp_i,
    input usbEpPkg::popPortT txPop_i,
    output logic txAvailable_o,
    output logic [7:0] txData_o,

    output usbEpPkg::pushPortT fifoPush_o [ENDPOINTS],
    input logic [ENDPOINTS-1:0] fifoFull_i,
    output usbEpPkg::popPortT fifoPop_o [ENDPOINTS],
    input logic [ENDPOINTS-1:0] fifoAvailable_i,
    input logic [7:0] fifoData_i [ENDPOINTS]
);

    always_comb begin
        rxFull_o = 1'b1; // An unknown endpoint never accepts
        for (int e = 0; e < ENDPOINTS; e++) begin
            fifoPush_o[e] = rxPush_i;
            if (rxEp_i == EP_W'(e)) begin
                rxFull_o = fifoFull_i[e];
            end else begin
                fifoPush_o[e].dataValid = 1'b0;
                fifoPush_o[e].transDone = 1'b0;
                fifoPush_o[e].transSuccess = 1'b0;
            end
        end
    end

    // Transmit strobes reach only the selected OUT FIFO
    always_comb begin
        txAvailable_o = 1'b0;
        txData_o = '0;
        for (int e = 0; e < ENDPOINTS; e++) begin
            fifoPop_o[e] = txPop_i;
            if (txEp_i == EP_W'(e)) begin
                txAvailable_o = fifoAvailable_i[e];
                txData_o = fifoData_i[e];
            end else begin
                fifoPop_o[e] = '0;
            end
        end
    end

endmodule

/* source/epTransFifo.sv */
module epTransFifo #(
    parameter int FIFO_DEPTH = 16,
    parameter int REGION = 0
)(
    input logic clk12_i,
    input logic rstN_i,
    input usbEpPkg::pushPortT push_i,
    output logic full_o,
    input usbEpPkg::popPortT pop_i,
    output logic dataAvailable_o,
    output logic [7:0] data_o,
    output usbEpPkg::bufReqT bufReq_o,
    input usbEpPkg::bufRspT bufRsp_i,
    input logic bufGrant_i
);
    import usbEpPkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W = IDX_W + 1; // Extra bit tells full from empty
    localparam logic [BUF_ADDR_W-1:0] BASE = BUF_ADDR_W'(REGION * FIFO_DEPTH);

    logic [PTR_W-1:0] wrPtr;    // Working write
    logic [PTR_W-1:0] wrCommit;
    logic [PTR_W-1:0] rdPtr;    // Next byte to pop
    logic [PTR_W-1:0] rdCommit;
    logic [PTR_W-1:0] wrNext;
    logic [PTR_W-1:0] rdNext;

    logic holdValid;
    logic [IDX_W-1:0] holdIdx;
    logic [7:0] holdData;

    fetchStateE fetchState;
    logic accept;
    logic popTaken;
    logic fetchReq;
    logic pushRollback;
    logic popRollback;

    // Space is only freed by a committed pop
    assign full_o = holdValid || ((wrPtr - rdCommit) == PTR_W'(FIFO_DEPTH));
    assign accept = push_i.dataValid && !full_o;
    assign wrNext = wrPtr + PTR_W'(accept);
    assign pushRollback = push_i.transDone && !push_i.transSuccess;

    assign dataAvailable_o = (fetchState == FETCH_READY);
    assign popTaken = pop_i.pop && dataAvailable_o;
    assign rdNext = rdPtr + PTR_W'(popTaken);
    assign popRollback = pop_i.transDone && !pop_i.transSuccess;
    assign fetchReq = (fetchState == FETCH_EMPTY) && (rdPtr != wrCommit);

    // Pending write wins over the prefetch read
    always_comb begin
        bufReq_o = '0;
        if (holdValid) begin
            bufReq_o.valid = 1'b1;
            bufReq_o.write = 1'b1;
            bufReq_o.addr = BASE + BUF_ADDR_W'(holdIdx);
            bufReq_o.data = holdData;
        end else if (fetchReq) begin
            bufReq_o.valid = 1'b1;
            bufReq_o.addr = BASE + BUF_ADDR_W'(rdPtr[IDX_W-1:0]);
        end
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr <= '0;
            wrCommit <= '0;
            holdValid <= 1'b0;
        end else begin
            if (pushRollback) begin
                wrPtr <= wrCommit;
            end else begin
                wrPtr <= wrNext;
                if (push_i.transDone) wrCommit <= wrNext; // Byte of this cycle included
            end

            if (accept) begin
                holdValid <= !pushRollback;
            end else if (holdValid && bufGrant_i) begin
                holdValid <= 1'b0; // Written to RAM
            end else if (pushRollback && (wrPtr != wrCommit)) begin
                holdValid <= 1'b0; // Held byte was never committed
            end
        end
    end

    always_ff @(posedge clk12_i) begin
        if (accept) begin
            holdData <= push_i.data;
            holdIdx <= wrPtr[IDX_W-1:0];
        end
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rdPtr <= '0;
            rdCommit <= '0;
            fetchState <= FETCH_EMPTY;
        end else if (popRollback) begin
            rdPtr <= rdCommit; // Replay from the last commit
            fetchState <= FETCH_EMPTY;
        end else begin
            rdPtr <= rdNext;
            if (pop_i.transDone) rdCommit <= rdNext;
            case (fetchState)
                FETCH_EMPTY: if (fetchReq && !holdValid && bufGrant_i) fetchState <= FETCH_WAIT;
                FETCH_WAIT: if (bufRsp_i.valid) fetchState <= FETCH_READY;
                FETCH_READY: if (popTaken) fetchState <= FETCH_EMPTY;
                default: fetchState <= FETCH_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk12_i) begin
        if (fetchState == FETCH_WAIT && bufRsp_i.valid) data_o <= bufRsp_i.data;
    end

endmodule

/* source/usbEpBuffers.sv */
module usbEpBuffers #(
    parameter int ENDPOINTS = 3,
    parameter int FIFO_DEPTH = 16,
    localparam int EP_W = $clog2(ENDPOINTS + 1)
)(
    input logic clk12_i,
    input logic rstN_i,

    // Engine side
    input logic [EP_W-1:0] rxEp_i,
    input usbEpPkg::pushPortT rxPush_i,
    output logic rxFull_o,
    input logic [EP_W-1:0] txEp_i,
    input usbEpPkg::popPortT txPop_i,
    output logic txAvailable_o,
    output logic [7:0] txData_o,

    // Backend side, index 0 is EP1
    input usbEpPkg::pushPortT epOutFill_i [ENDPOINTS],
    output logic [ENDPOINTS-1:0] epOutFull_o,
    input usbEpPkg::popPortT epInPop_i [ENDPOINTS],
    output logic [ENDPOINTS-1:0] epInAvailable_o,
    output logic [7:0] epInData_o [ENDPOINTS]
);
    import usbEpPkg::*;

    localparam int REQUESTERS = 2 * ENDPOINTS; // IN FIFOs first, then OUT FIFOs

    if (REQUESTERS * FIFO_DEPTH > 2 ** BUF_ADDR_W) begin : gCapacityCheck
        $error("Endpoint FIFOs do not fit into the shared buffer");
    end
    if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : gDepthCheck
        $error("FIFO_DEPTH must be a power of two");
    end

    pushPortT rxFifoPush [ENDPOINTS];
    logic [ENDPOINTS-1:0] rxFifoFull;
    popPortT txFifoPop [ENDPOINTS];
    logic [ENDPOINTS-1:0] txFifoAvailable;
    logic [7:0] txFifoData [ENDPOINTS];

    bufReqT bufReq [REQUESTERS];
    bufRspT bufRsp [REQUESTERS];
    logic [REQUESTERS-1:0] bufGrant;

    logic ramEn;
    logic ramWe;
    logic [BUF_ADDR_W-1:0] ramAddr;
    logic [7:0] ramWdata;
    logic [7:0] ramRdata;

    for (genvar e = 0; e < ENDPOINTS; e++) begin : gEp
        epTransFifo #(
            .FIFO_DEPTH(FIFO_DEPTH),
            .REGION(e)
        ) inFifo (
            .clk12_i(clk12_i),
            .rstN_i(rstN_i),
            .push_i(rxFifoPush[e]),
            .full_o(rxFifoFull[e]),
            .pop_i(epInPop_i[e]),
            .dataAvailable_o(epInAvailable_o[e]),
            .data_o(epInData_o[e]),
            .bufReq_o(bufReq[e]),
            .bufRsp_i(bufRsp[e]),
            .bufGrant_i(bufGrant[e])
        );

        epTransFifo #(
            .FIFO_DEPTH(FIFO_DEPTH),
            .REGION(ENDPOINTS + e)
        ) outFifo (
            .clk12_i(clk12_i),
            .rstN_i(rstN_i),
            .push_i(epOutFill_i[e]),
            .full_o(epOutFull_o[e]),
            .pop_i(txFifoPop[e]),
            .dataAvailable_o(txFifoAvailable[e]),
            .data_o(txFifoData[e]),
            .bufReq_o(bufReq[ENDPOINTS + e]),
            .bufRsp_i(bufRsp[ENDPOINTS + e]),
            .bufGrant_i(bufGrant[ENDPOINTS + e])
        );
    end

    epPortMux #(
        .ENDPOINTS(ENDPOINTS)
    ) mux0 (
        .rxEp_i(rxEp_i),
        .rxPush_i(rxPush_i),
        .rxFull_o(rxFull_o),
        .txEp_i(txEp_i),
        .txPop_i(txPop_i),
        .txAvailable_o(txAvailable_o),
        .txData_o(txData_o),
        .fifoPush_o(rxFifoPush),
        .fifoFull_i(rxFifoFull),
        .fifoPop_o(txFifoPop),
        .fifoAvailable_i(txFifoAvailable),
        .fifoData_i(txFifoData)
    );

    bufferArbiter #(
        .REQUESTERS(REQUESTERS)
    ) arb0 (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .req_i(bufReq),
        .grant_o(bufGrant),
        .rsp_o(bufRsp),
        .ramEn_o(ramEn),
        .ramWe_o(ramWe),
        .ramAddr_o(ramAddr),
        .ramWdata_o(ramWdata),
        .ramRdata_i(ramRdata)
    );

    bufferRam ram0 (
        .clk12_i(clk12_i),
        .en_i(ramEn),
        .we_i(ramWe),
        .addr_i(ramAddr),
        .wdata_i(ramWdata),
        .rdata_o(ramRdata)
    );

endmodule

/* source/usbEpPkg.sv */
package usbEpPkg;

    // Shared buffer holds every endpoint FIFO, 256 bytes
    parameter int BUF_ADDR_W = 8;

    // One FIFO's access to the shared RAM
    typedef struct packed {
        logic valid;
        logic write; // Low for a prefetch read
        logic [BUF_ADDR_W-1:0] addr;
        logic [7:0] data;
    } bufReqT;

    // Read data returned to the granted requester
    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } bufRspT;

    // Fill side of a transactional FIFO
    typedef struct packed {
        logic dataValid;
        logic [7:0] data;
        logic transDone;
        logic transSuccess; // Commit when set, roll back otherwise
    } pushPortT;

    // Drain side of a transactional FIFO
    typedef struct packed {
        logic pop;
        logic transDone;
        logic transSuccess;
    } popPortT;

    // Output byte prefetch
    typedef enum logic [1:0] {
        FETCH_EMPTY, // Output register holds nothing
        FETCH_WAIT,  // Read granted, data arrives this cycle
        FETCH_READY  // Output byte valid
    } fetchStateE;

endpackage

/* tb.f */
source/usbEpPkg.sv
source/bufferRam.sv
source/bufferArbiter.sv
source/epTransFifo.sv
source/epPortMux.sv
source/usbEpBuffers.sv
sim/usbEpBuffers_chk.sv
sim/tbUsbEpBuffers.sv
